/* Makefile */
TOP := tb_pipe_trace

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --top-module pipe_trace_top \
		source/pipe_trace_pkg.sv source/stage_bus_if.sv source/stage_tracker.sv \
		source/timestamp_table.sv source/retire_reporter.sv source/pipe_trace_top.sv

clean:
	rm -rf obj_dir

/* filelist.f */
source/pipe_trace_pkg.sv
source/stage_bus_if.sv
source/stage_tracker.sv
source/timestamp_table.sv
source/retire_reporter.sv
source/pipe_trace_top.sv
testbench/tb_pipe_trace.sv

/* source/pipe_trace_pkg.sv */
// Shared widths, table depth and stage indices for the pipeline trace unit and its testbench
package pipe_trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline shape
    ////////////////////////////////////////////////////////////////////////////

    localparam int STAGE_COUNT = 5;  // Fetch, decode, execute, memory, write-back

    // Position of each stage in the tracker's valid and tag arrays
    localparam int STG_IF  = 0;
    localparam int STG_ID  = 1;
    localparam int STG_EX  = 2;
    localparam int STG_MEM = 3;
    localparam int STG_WB  = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Trace widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int INST_ID_W = 8;
    localparam int CYCLE_W   = 16;
    localparam int COUNT_W   = 16;

    // Covers the five instructions that can be in flight at once
    localparam int TABLE_DEPTH = 8;
    localparam int TABLE_IDX_W = $clog2(TABLE_DEPTH);

    typedef logic [INST_ID_W-1:0]   inst_id_t;    // Accepted instruction number, wraps
    typedef logic [CYCLE_W-1:0]     cycle_t;      // Cycle count, timestamps, latencies
    typedef logic [COUNT_W-1:0]     count_t;      // Stall cycles and flush totals
    typedef logic [TABLE_IDX_W-1:0] table_idx_t;  // Low bits of an instruction tag

endpackage

/* source/pipe_trace_top.sv */
// Pipeline trace unit top level, driven by issue, stall and flush strobes and producing retire records
module pipe_trace_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic                     stall,
    input  logic                     flush,
    output pipe_trace_pkg::count_t   flushed_count,
    output logic                     retire_valid,
    output pipe_trace_pkg::inst_id_t retire_id,
    output pipe_trace_pkg::cycle_t   retire_fetch_cycle,
    output pipe_trace_pkg::count_t   retire_stall_cycles,
    output pipe_trace_pkg::cycle_t   retire_latency
);

    pipe_trace_pkg::cycle_t wb_fetch_cycle;   // Table lookup at write-back
    pipe_trace_pkg::count_t wb_stall_cycles;

    stage_bus bus ();

    stage_tracker u_tracker (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .stall         (stall),
        .flush         (flush),
        .bus           (bus.tracker),
        .flushed_count (flushed_count)
    );

    timestamp_table u_table (
        .clk             (clk),
        .rst             (rst),
        .bus             (bus.tbl),
        .wb_fetch_cycle  (wb_fetch_cycle),
        .wb_stall_cycles (wb_stall_cycles)
    );

    // Adds the one register stage of the retire path
    retire_reporter u_reporter (
        .clk                 (clk),
        .rst                 (rst),
        .bus                 (bus.reporter),
        .wb_fetch_cycle      (wb_fetch_cycle),
        .wb_stall_cycles     (wb_stall_cycles),
        .retire_valid        (retire_valid),
        .retire_id           (retire_id),
        .retire_fetch_cycle  (retire_fetch_cycle),
        .retire_stall_cycles (retire_stall_cycles),
        .retire_latency      (retire_latency)
    );

endmodule

/* source/retire_reporter.sv */
// Registers one retire record per instruction leaving write-back, with fetch cycle, stalls and latency
module retire_reporter (
    input  logic                     clk,
    input  logic                     rst,
    stage_bus.reporter               bus,
    input  pipe_trace_pkg::cycle_t   wb_fetch_cycle,
    input  pipe_trace_pkg::count_t   wb_stall_cycles,
    output logic                     retire_valid,
    output pipe_trace_pkg::inst_id_t retire_id,
    output pipe_trace_pkg::cycle_t   retire_fetch_cycle,
    output pipe_trace_pkg::count_t   retire_stall_cycles,
    output pipe_trace_pkg::cycle_t   retire_latency
);

    pipe_trace_pkg::cycle_t latency;

    assign latency = bus.now - wb_fetch_cycle;  // Wraps with the cycle counter

    // One-cycle pulse per retiring instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= bus.wb_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Record fields
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.wb_valid) begin
            retire_id           <= bus.wb_id;
            retire_fetch_cycle  <= wb_fetch_cycle;
            retire_stall_cycles <= wb_stall_cycles;
            retire_latency      <= latency;
        end
    end

    // Timestamp written at accept and read at write-back in another module,
    // so a stale or overwritten entry shows up as a short latency
    min_latency: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_latency >= pipe_trace_pkg::cycle_t'(pipe_trace_pkg::STAGE_COUNT - 1));

endmodule

/* source/stage_bus_if.sv */
// Stage occupancy, tags and cycle count shared by the tracker, the timestamp table and the reporter
interface stage_bus;

    pipe_trace_pkg::cycle_t   now;        // Cycles since reset release
    logic                     accept;     // New instruction taken at this edge
    pipe_trace_pkg::inst_id_t accept_id;
    logic                     if_valid;
    pipe_trace_pkg::inst_id_t if_id;
    logic                     id_valid;
    pipe_trace_pkg::inst_id_t id_id;
    logic                     hold;       // Fetch and decode frozen by a stall
    logic                     wb_valid;
    pipe_trace_pkg::inst_id_t wb_id;

    modport tracker (
        output now, accept, accept_id, if_valid, if_id, id_valid, id_id, hold, wb_valid, wb_id
    );

    // Timestamp table side
    modport tbl (
        input now, accept, accept_id, if_valid, if_id, id_valid, id_id, hold, wb_id
    );

    modport reporter (
        input now, wb_valid, wb_id
    );

endinterface

/* source/stage_tracker.sv */
// Follows instruction tags through the five pipeline stages under stall and flush and counts cycles
module stage_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  logic                   stall,
    input  logic                   flush,
    stage_bus.tracker              bus,
    output pipe_trace_pkg::count_t flushed_count
);

    logic [pipe_trace_pkg::STAGE_COUNT-1:0] valid_q;
    pipe_trace_pkg::inst_id_t               tag_q [pipe_trace_pkg::STAGE_COUNT];
    pipe_trace_pkg::inst_id_t               next_tag_q;
    pipe_trace_pkg::cycle_t                 now_q;
    pipe_trace_pkg::count_t                 flushed_q;
    logic                                   accept;
    logic                                   hold;
    logic [1:0]                             flush_num;

    assign accept    = issue && !stall && !flush;
    assign hold      = stall && !flush;  // Flush wins over stall
    assign flush_num = 2'(valid_q[pipe_trace_pkg::STG_IF]) + 2'(valid_q[pipe_trace_pkg::STG_ID]);

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy and counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            next_tag_q <= '0;
            now_q      <= '0;
            flushed_q  <= '0;
        end else begin
            now_q <= now_q + 1'b1;

            // Back end never stalls
            valid_q[pipe_trace_pkg::STG_WB]  <= valid_q[pipe_trace_pkg::STG_MEM];
            valid_q[pipe_trace_pkg::STG_MEM] <= valid_q[pipe_trace_pkg::STG_EX];

            if (flush) begin
                valid_q[pipe_trace_pkg::STG_IF] <= 1'b0;
                valid_q[pipe_trace_pkg::STG_ID] <= 1'b0;
                valid_q[pipe_trace_pkg::STG_EX] <= 1'b0;
                flushed_q <= flushed_q + pipe_trace_pkg::count_t'(flush_num);
            end else if (stall) begin
                valid_q[pipe_trace_pkg::STG_EX] <= 1'b0;  // Bubble into execute
            end else begin
                valid_q[pipe_trace_pkg::STG_EX] <= valid_q[pipe_trace_pkg::STG_ID];
                valid_q[pipe_trace_pkg::STG_ID] <= valid_q[pipe_trace_pkg::STG_IF];
                valid_q[pipe_trace_pkg::STG_IF] <= issue;
            end

            if (accept) begin
                next_tag_q <= next_tag_q + 1'b1;
            end
        end
    end

    // Tags only mean something where the valid bit is set
    always_ff @(posedge clk) begin
        tag_q[pipe_trace_pkg::STG_WB]  <= tag_q[pipe_trace_pkg::STG_MEM];
        tag_q[pipe_trace_pkg::STG_MEM] <= tag_q[pipe_trace_pkg::STG_EX];
        if (!(stall || flush)) begin
            tag_q[pipe_trace_pkg::STG_EX] <= tag_q[pipe_trace_pkg::STG_ID];
            tag_q[pipe_trace_pkg::STG_ID] <= tag_q[pipe_trace_pkg::STG_IF];
            tag_q[pipe_trace_pkg::STG_IF] <= next_tag_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage bus
    ////////////////////////////////////////////////////////////////////////////

    assign bus.now       = now_q;
    assign bus.accept    = accept;
    assign bus.accept_id = next_tag_q;
    assign bus.if_valid  = valid_q[pipe_trace_pkg::STG_IF];
    assign bus.if_id     = tag_q[pipe_trace_pkg::STG_IF];
    assign bus.id_valid  = valid_q[pipe_trace_pkg::STG_ID];
    assign bus.id_id     = tag_q[pipe_trace_pkg::STG_ID];
    assign bus.hold      = hold;
    assign bus.wb_valid  = valid_q[pipe_trace_pkg::STG_WB];
    assign bus.wb_id     = tag_q[pipe_trace_pkg::STG_WB];

    assign flushed_count = flushed_q;

    // Back-to-back write-back occupants are consecutive accepts, a flush
    // can only open a gap where a bubble already separates them
    wb_tag_order: assert property (@(posedge clk) disable iff (rst)
        valid_q[pipe_trace_pkg::STG_WB] && $past(valid_q[pipe_trace_pkg::STG_WB])
        |-> tag_q[pipe_trace_pkg::STG_WB]
            == pipe_trace_pkg::inst_id_t'($past(tag_q[pipe_trace_pkg::STG_WB]) + 1'b1));

endmodule

/* source/timestamp_table.sv */
// Per-instruction fetch cycle and stall count, written from the stage bus and read at write-back
module timestamp_table (
    input  logic                   clk,
    input  logic                   rst,
    stage_bus.tbl                  bus,
    output pipe_trace_pkg::cycle_t wb_fetch_cycle,
    output pipe_trace_pkg::count_t wb_stall_cycles
);

    pipe_trace_pkg::cycle_t     fetch_mem [pipe_trace_pkg::TABLE_DEPTH];
    pipe_trace_pkg::count_t     stall_mem [pipe_trace_pkg::TABLE_DEPTH];
    pipe_trace_pkg::table_idx_t acc_idx;
    pipe_trace_pkg::table_idx_t if_idx;
    pipe_trace_pkg::table_idx_t id_idx;
    pipe_trace_pkg::table_idx_t wb_idx;

    // Entry picked by the low tag bits
    assign acc_idx = pipe_trace_pkg::table_idx_t'(bus.accept_id);
    assign if_idx  = pipe_trace_pkg::table_idx_t'(bus.if_id);
    assign id_idx  = pipe_trace_pkg::table_idx_t'(bus.id_id);
    assign wb_idx  = pipe_trace_pkg::table_idx_t'(bus.wb_id);

    ////////////////////////////////////////////////////////////////////////////
    // Writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // Accept and hold never coincide
        if (bus.accept) begin
            fetch_mem[acc_idx] <= bus.now;  // Fetch timestamp
            stall_mem[acc_idx] <= '0;
        end

        if (bus.hold) begin
            if (bus.if_valid) begin
                stall_mem[if_idx] <= stall_mem[if_idx] + 1'b1;
            end
            if (bus.id_valid) begin
                stall_mem[id_idx] <= stall_mem[id_idx] + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back lookup
    ////////////////////////////////////////////////////////////////////////////

    assign wb_fetch_cycle  = fetch_mem[wb_idx];
    assign wb_stall_cycles = stall_mem[wb_idx];

    // Two live front-end instructions never share an entry, or the stall
    // increments above would collide
    front_idx_distinct: assert property (@(posedge clk) disable iff (rst)
        bus.if_valid && bus.id_valid |-> if_idx != id_idx);

endmodule

/* testbench/tb_pipe_trace.sv */
// Self-checking testbench for the pipeline trace unit, random issue, stall and flush against a model
module tb_pipe_trace;

    localparam int CLEAN_CYCLES  = 40;    // Opening stretch with no stall or flush
    localparam int RANDOM_CYCLES = 3000;
    localparam int DRAIN_TIMEOUT = 50;
    localparam int MIN_RETIRES   = 300;   // Enough to wrap the 8-bit tag

    typedef struct packed {
        pipe_trace_pkg::inst_id_t id;
        pipe_trace_pkg::cycle_t   fetch_cycle;
        pipe_trace_pkg::count_t   stall_cycles;
        pipe_trace_pkg::cycle_t   latency;
    } retire_rec_t;

    logic                     clk;
    logic                     rst;
    logic                     issue;
    logic                     stall;
    logic                     flush;
    pipe_trace_pkg::count_t   flushed_count;
    logic                     retire_valid;
    pipe_trace_pkg::inst_id_t retire_id;
    pipe_trace_pkg::cycle_t   retire_fetch_cycle;
    pipe_trace_pkg::count_t   retire_stall_cycles;
    pipe_trace_pkg::cycle_t   retire_latency;

    int seed = 32'hc624_1cc4;
    int retired_total = 0;
    int stalled_retires = 0;

    // Reference model, one slot per stage
    logic                     m_valid [pipe_trace_pkg::STAGE_COUNT];
    pipe_trace_pkg::inst_id_t m_tag   [pipe_trace_pkg::STAGE_COUNT];
    pipe_trace_pkg::cycle_t   m_fetch [pipe_trace_pkg::STAGE_COUNT];
    pipe_trace_pkg::count_t   m_stall [pipe_trace_pkg::STAGE_COUNT];
    pipe_trace_pkg::inst_id_t m_next_tag;
    pipe_trace_pkg::cycle_t   m_now;
    pipe_trace_pkg::count_t   m_flushed;
    retire_rec_t              exp_q [$];  // Records due on the next edge

    initial clk = 1'b0;
    always #5 clk = ~clk;

    pipe_trace_top DUT (
        .clk                 (clk),
        .rst                 (rst),
        .issue               (issue),
        .stall               (stall),
        .flush               (flush),
        .flushed_count       (flushed_count),
        .retire_valid        (retire_valid),
        .retire_id           (retire_id),
        .retire_fetch_cycle  (retire_fetch_cycle),
        .retire_stall_cycles (retire_stall_cycles),
        .retire_latency      (retire_latency)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and typed compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_id(input string name, input pipe_trace_pkg::inst_id_t got,
                            input pipe_trace_pkg::inst_id_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic match_cycle(input string name, input pipe_trace_pkg::cycle_t got,
                               input pipe_trace_pkg::cycle_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic expect_count(input string name, input pipe_trace_pkg::count_t got,
                                input pipe_trace_pkg::count_t exp);
        if (got !== exp) begin
            end_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            end_with_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic void reset_model();
        for (int s = 0; s < pipe_trace_pkg::STAGE_COUNT; s++) begin
            m_valid[s] = 1'b0;
            m_tag[s]   = '0;
            m_fetch[s] = '0;
            m_stall[s] = '0;
        end
        m_next_tag = '0;
        m_now      = '0;
        m_flushed  = '0;
        exp_q.delete();
    endfunction

    // One rising edge of the pipeline rules
    function automatic void step_model(input logic issue_s, input logic stall_s,
                                       input logic flush_s);
        retire_rec_t rec;
        if (m_valid[pipe_trace_pkg::STG_WB]) begin
            rec.id           = m_tag[pipe_trace_pkg::STG_WB];
            rec.fetch_cycle  = m_fetch[pipe_trace_pkg::STG_WB];
            rec.stall_cycles = m_stall[pipe_trace_pkg::STG_WB];
            rec.latency      = m_now - m_fetch[pipe_trace_pkg::STG_WB];
            exp_q.push_back(rec);
        end
        for (int s = pipe_trace_pkg::STG_WB; s > pipe_trace_pkg::STG_EX; s--) begin
            m_valid[s] = m_valid[s-1];  // Back end always moves
            m_tag[s]   = m_tag[s-1];
            m_fetch[s] = m_fetch[s-1];
            m_stall[s] = m_stall[s-1];
        end
        if (flush_s) begin
            m_flushed = m_flushed + pipe_trace_pkg::count_t'(m_valid[pipe_trace_pkg::STG_IF])
                                  + pipe_trace_pkg::count_t'(m_valid[pipe_trace_pkg::STG_ID]);
            m_valid[pipe_trace_pkg::STG_IF] = 1'b0;
            m_valid[pipe_trace_pkg::STG_ID] = 1'b0;
            m_valid[pipe_trace_pkg::STG_EX] = 1'b0;
        end else if (stall_s) begin
            for (int s = pipe_trace_pkg::STG_IF; s <= pipe_trace_pkg::STG_ID; s++) begin
                if (m_valid[s]) begin
                    m_stall[s] = m_stall[s] + pipe_trace_pkg::count_t'(1);
                end
            end
            m_valid[pipe_trace_pkg::STG_EX] = 1'b0;
        end else begin
            for (int s = pipe_trace_pkg::STG_EX; s > pipe_trace_pkg::STG_IF; s--) begin
                m_valid[s] = m_valid[s-1];
                m_tag[s]   = m_tag[s-1];
                m_fetch[s] = m_fetch[s-1];
                m_stall[s] = m_stall[s-1];
            end
            m_valid[pipe_trace_pkg::STG_IF] = issue_s;
            m_tag[pipe_trace_pkg::STG_IF]   = m_next_tag;
            m_fetch[pipe_trace_pkg::STG_IF] = m_now;
            m_stall[pipe_trace_pkg::STG_IF] = '0;
            if (issue_s) begin
                m_next_tag = m_next_tag + pipe_trace_pkg::inst_id_t'(1);
            end
        end
        m_now = m_now + pipe_trace_pkg::cycle_t'(1);
    endfunction

    function automatic logic pipeline_busy();
        logic busy;
        busy = (exp_q.size() != 0);
        for (int s = 0; s < pipe_trace_pkg::STAGE_COUNT; s++) begin
            busy = busy | m_valid[s];
        end
        return busy;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare process, sees the values from before each edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        retire_rec_t rec;
        if (rst) begin
            reset_model();
        end else begin
            expect_count("flushed_count", flushed_count, m_flushed);
            verify_flag("retire_valid", retire_valid, exp_q.size() != 0);
            if (retire_valid) begin
                rec = exp_q.pop_front();
                check_id("retire_id", retire_id, rec.id);
                match_cycle("retire_fetch_cycle", retire_fetch_cycle, rec.fetch_cycle);
                expect_count("retire_stall_cycles", retire_stall_cycles, rec.stall_cycles);
                match_cycle("retire_latency", retire_latency, rec.latency);
                // Depth of five plus one edge per stall
                match_cycle("retire_latency minus stalls", retire_latency,
                            pipe_trace_pkg::cycle_t'(pipe_trace_pkg::STAGE_COUNT)
                            + retire_stall_cycles);
                retired_total++;
                if (retire_stall_cycles != '0) begin
                    stalled_retires++;
                end
            end
            step_model(issue, stall, flush);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int r;
        int stall_left;
        int drain_cycles;
        rst   = 1'b1;
        issue = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int c = 0; c < CLEAN_CYCLES; c++) begin
            @(posedge clk);
            r = $random(seed);
            issue <= (r[1:0] != 2'b00);
        end

        stall_left = 0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            @(posedge clk);
            r = $random(seed);
            if (stall_left == 0 && r[7:4] == 4'h0) begin
                stall_left = int'(r[10:9]) + 1;  // Bursts of one to four edges
            end
            issue <= (r[1:0] != 2'b00);
            stall <= (stall_left != 0);
            flush <= (r[15:11] == 5'h00);
            if (stall_left != 0) begin
                stall_left--;
            end
        end

        @(posedge clk);
        issue <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;

        // Drain, sampled away from the active edge
        drain_cycles = 0;
        @(negedge clk);
        while (pipeline_busy()) begin
            if (drain_cycles == DRAIN_TIMEOUT) begin
                end_with_failure("Timeout waiting for the last retire records");
            end
            @(negedge clk);
            drain_cycles++;
        end
        @(negedge clk);  // One more compare on the idle outputs

        $display("%0d retired, %0d with stalls, %0d flushed",
                 retired_total, stalled_retires, m_flushed);
        if (retired_total < MIN_RETIRES || stalled_retires == 0 || m_flushed == '0) begin
            end_with_failure("Run too short to wrap the tags or to see stalls and flushes");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
